/* rtl/commit_params.svh */
`ifndef COMMIT_PARAMS_SVH
`define COMMIT_PARAMS_SVH

// data word width
`define COMMIT_XLEN 32

// register number width
`define COMMIT_RAW 5

// one instruction, used to step back from pc+4
`define COMMIT_INSTR_BYTES 4

`endif

/* rtl/commit_pkg.sv */
`include "commit_params.svh"

package commit_pkg;

    typedef logic [`COMMIT_XLEN-1:0] word_t;
    typedef logic [`COMMIT_RAW-1:0]  reg_addr_t;

    // operations that can still be pending at commit
    typedef enum logic [3:0] {
        OP_NOP,
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_SLL,
        OP_LB,
        OP_LBU,
        OP_LH,
        OP_LHU,
        OP_LW,
        OP_SW
    } commit_op_t;

    // loads and stores share the data memory port
    function automatic logic is_mem_op(commit_op_t op);
        logic hit;
        case (op)
            OP_LB,
            OP_LBU,
            OP_LH,
            OP_LHU,
            OP_LW,
            OP_SW:   hit = 1'b1;
            default: hit = 1'b0;
        endcase
        return hit;
    endfunction

endpackage

/* rtl/lane_if.sv */
`timescale 1ns/1ps

interface lane_if;
    import commit_pkg::*;

    commit_op_t op;
    word_t      srca;
    word_t      srcb;

    // filled in by the late alu
    word_t      alu_result;

    modport exec (
        input  op,
        input  srca,
        input  srcb,
        output alu_result
    );

    modport load (
        input  op
    );

    modport merge (
        input  op,
        input  srca,
        input  srcb,
        input  alu_result
    );

endinterface

/* rtl/mem_if.sv */
`timescale 1ns/1ps

interface mem_if;
    import commit_pkg::*;

    // raw response from data memory
    logic  en;
    word_t addr;
    word_t rd;
    logic  data_ok;

    // formatted load and completion flag
    word_t load_data;
    logic  finish;

    modport capture (
        input  en,
        input  addr,
        input  rd,
        input  data_ok,
        output load_data,
        output finish
    );

    modport merge (
        input  load_data,
        input  finish
    );

endinterface

/* rtl/late_alu.sv */
`timescale 1ns/1ps

module late_alu (
    lane_if.exec l1,
    lane_if.exec l0
);
    import commit_pkg::*;

    // simple ops whose evaluation was pushed into commit
    function automatic word_t alu_eval(commit_op_t op, word_t a, word_t b);
        word_t r;
        case (op)
            OP_ADD:
            begin
                r = a + b;
            end
            OP_SUB:
            begin
                r = a - b;
            end
            OP_AND:
            begin
                r = a & b;
            end
            OP_OR:
            begin
                r = a | b;
            end
            OP_XOR:
            begin
                r = a ^ b;
            end
            OP_SLT:
            begin
                r = word_t'($signed(a) < $signed(b));
            end
            OP_SLL:
            begin
                // shift amount is the low five bits only
                r = a << b[4:0];
            end
            default:
            begin
                // nop and memory ops have no alu result
                r = '0;
            end
        endcase
        return r;
    endfunction

    // older slot
    assign l1.alu_result = alu_eval(l1.op, l1.srca, l1.srcb);

    // younger slot
    assign l0.alu_result = alu_eval(l0.op, l0.srca, l0.srcb);

endmodule

/* rtl/load_capture.sv */
`timescale 1ns/1ps
`include "commit_params.svh"

module load_capture (
    input logic      clk,
    input logic      rst,
    input logic      stall,
    lane_if.load     l1,
    lane_if.load     l0,
    mem_if.capture   mem
);
    import commit_pkg::*;

    logic       held_ok;
    word_t      held_rd;
    word_t      rd_sel;
    commit_op_t mem_op;

    // pick out the addressed field and extend it
    function automatic word_t format_load(commit_op_t op, word_t data, logic [1:0] off);
        logic [7:0]  b;
        logic [15:0] h;
        word_t       r;
        b = data[8*off +: 8];
        h = data[16*off[1] +: 16];
        case (op)
            OP_LB:   r = {{(`COMMIT_XLEN-8){b[7]}}, b};
            OP_LBU:  r = {{(`COMMIT_XLEN-8){1'b0}}, b};
            OP_LH:   r = {{(`COMMIT_XLEN-16){h[15]}}, h};
            OP_LHU:  r = {{(`COMMIT_XLEN-16){1'b0}}, h};
            OP_LW:   r = data;
            default: r = '0;
        endcase
        return r;
    endfunction

    // response seen during a stall survives until the stall lifts
    always_ff @(posedge clk)
    begin
        if (rst || !stall)
        begin
            held_ok <= 1'b0;
        end
        else if (mem.data_ok)
        begin
            held_ok <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (stall && mem.data_ok)
        begin
            held_rd <= mem.rd;
        end
    end

    // live data wins over the copy
    assign rd_sel = mem.data_ok ? mem.rd : held_rd;

    // only one lane uses memory, the older one first
    assign mem_op = is_mem_op(l1.op) ? l1.op : l0.op;

    assign mem.load_data = format_load(mem_op, rd_sel, mem.addr[1:0]);

    // done if nothing was asked for, or the answer came now or earlier
    assign mem.finish = !mem.en || mem.data_ok || held_ok;

endmodule

/* rtl/commit_merge.sv */
`timescale 1ns/1ps
`include "commit_params.svh"

module commit_merge (
    lane_if.merge                l1,
    lane_if.merge                l0,
    mem_if.merge                 mem,
    input  commit_pkg::reg_addr_t destreg1,
    input  commit_pkg::reg_addr_t destreg0,
    input  logic                 regwrite1,
    input  logic                 regwrite0,
    input  commit_pkg::word_t    pcplus4_1,
    input  commit_pkg::word_t    pcplus4_0,
    input  logic                 branch,
    input  logic                 taken,
    input  logic                 pred_taken,
    input  commit_pkg::word_t    pcbranch,
    output commit_pkg::word_t    result1,
    output commit_pkg::word_t    result0,
    output logic                 ready1,
    output logic                 ready0,
    output logic                 redirect,
    output commit_pkg::word_t    redirect_pc,
    output commit_pkg::word_t    pc_commit,
    output logic                 predict_wen
);
    import commit_pkg::*;

    logic mem1;
    logic mem0;

    assign mem1 = is_mem_op(l1.op);
    assign mem0 = is_mem_op(l0.op);

    // final value per lane
    assign result1 = mem1 ? mem.load_data : l1.alu_result;
    assign result0 = mem0 ? mem.load_data : l0.alu_result;

    // a memory lane is not ready until its access finishes
    assign ready1 = !(mem1 && !mem.finish);
    assign ready0 = !(mem0 && !mem.finish);

    // destreg/regwrite go to the bypass network from the top level,
    // only results and ready bits are formed here

    // branch sits in the older slot, delay slot in lane 0
    assign redirect = branch && (taken != pred_taken);

    // wrongly predicted taken falls through past the delay slot
    assign redirect_pc = pred_taken ? pcplus4_0 : pcbranch;

    // predictor update
    assign pc_commit   = pcplus4_1 - word_t'(`COMMIT_INSTR_BYTES);
    assign predict_wen = branch;

endmodule

/* rtl/commit_top.sv */
`timescale 1ns/1ps

module commit_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  stall,
    input  commit_pkg::commit_op_t op1,
    input  commit_pkg::word_t     srca1,
    input  commit_pkg::word_t     srcb1,
    input  commit_pkg::reg_addr_t destreg1,
    input  logic                  regwrite1,
    input  commit_pkg::word_t     pcplus4_1,
    input  commit_pkg::commit_op_t op0,
    input  commit_pkg::word_t     srca0,
    input  commit_pkg::word_t     srcb0,
    input  commit_pkg::reg_addr_t destreg0,
    input  logic                  regwrite0,
    input  commit_pkg::word_t     pcplus4_0,
    input  logic                  dmem_en,
    input  commit_pkg::word_t     dmem_addr,
    input  commit_pkg::word_t     dmem_rd,
    input  logic                  dmem_data_ok,
    input  logic                  branch,
    input  logic                  taken,
    input  logic                  pred_taken,
    input  commit_pkg::word_t     pcbranch,
    output commit_pkg::word_t     result1,
    output commit_pkg::word_t     result0,
    output logic                  ready1,
    output logic                  ready0,
    output commit_pkg::reg_addr_t byp_destreg1,
    output commit_pkg::reg_addr_t byp_destreg0,
    output logic                  byp_wen1,
    output logic                  byp_wen0,
    output logic                  finish,
    output logic                  redirect,
    output commit_pkg::word_t     redirect_pc,
    output commit_pkg::word_t     pc_commit,
    output logic                  predict_wen
);

    lane_if lane1_bus ();
    lane_if lane0_bus ();
    mem_if  mem_bus ();

    assign lane1_bus.op   = op1;
    assign lane1_bus.srca = srca1;
    assign lane1_bus.srcb = srcb1;
    assign lane0_bus.op   = op0;
    assign lane0_bus.srca = srca0;
    assign lane0_bus.srcb = srcb0;

    assign mem_bus.en      = dmem_en;
    assign mem_bus.addr    = dmem_addr;
    assign mem_bus.rd      = dmem_rd;
    assign mem_bus.data_ok = dmem_data_ok;
    assign finish          = mem_bus.finish;

    // bypass destinations come straight from the lanes
    assign byp_destreg1 = destreg1;
    assign byp_destreg0 = destreg0;
    assign byp_wen1     = regwrite1;
    assign byp_wen0     = regwrite0;

    late_alu u_late_alu (
        .l1 (lane1_bus.exec),
        .l0 (lane0_bus.exec)
    );

    load_capture u_load_capture (
        .clk   (clk),
        .rst   (rst),
        .stall (stall),
        .l1    (lane1_bus.load),
        .l0    (lane0_bus.load),
        .mem   (mem_bus.capture)
    );

    commit_merge u_commit_merge (
        .l1          (lane1_bus.merge),
        .l0          (lane0_bus.merge),
        .mem         (mem_bus.merge),
        .destreg1    (destreg1),
        .destreg0    (destreg0),
        .regwrite1   (regwrite1),
        .regwrite0   (regwrite0),
        .pcplus4_1   (pcplus4_1),
        .pcplus4_0   (pcplus4_0),
        .branch      (branch),
        .taken       (taken),
        .pred_taken  (pred_taken),
        .pcbranch    (pcbranch),
        .result1     (result1),
        .result0     (result0),
        .ready1      (ready1),
        .ready0      (ready0),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .pc_commit   (pc_commit),
        .predict_wen (predict_wen)
    );

endmodule

/* sim/commit_checker.sv */
`timescale 1ns/1ps

module commit_checker (
    input logic                   clk,
    input logic                   rst,
    input logic                   dmem_en,
    input logic                   dmem_data_ok,
    input logic                   finish,
    input logic                   branch,
    input logic                   redirect,
    input logic                   ready1,
    input logic                   ready0,
    input commit_pkg::commit_op_t op1,
    input commit_pkg::commit_op_t op0
);
    import commit_pkg::*;

    // no request means nothing to wait for
    assert property (@(posedge clk) !dmem_en |-> finish)
        else $error("finish low while dmem_en is low");

    assert property (@(posedge clk) redirect |-> branch)
        else $error("redirect raised without a branch");

    // reset leaves no held response behind
    assert property (@(posedge clk) $fell(rst) |-> (finish == (dmem_data_ok || !dmem_en)))
        else $error("finish after reset does not follow the live response");

    // alu-only pairs never wait on memory
    assert property (@(posedge clk) disable iff (rst)
        (!is_mem_op(op1) && !is_mem_op(op0)) |-> (ready1 && ready0))
        else $error("non-memory lanes reported not ready");

endmodule

bind commit_top commit_checker u_checker (
    .clk          (clk),
    .rst          (rst),
    .dmem_en      (dmem_en),
    .dmem_data_ok (dmem_data_ok),
    .finish       (finish),
    .branch       (branch),
    .redirect     (redirect),
    .ready1       (ready1),
    .ready0       (ready0),
    .op1          (op1),
    .op0          (op0)
);

/* sim/commit_tb.sv */
`timescale 1ns/1ps
`include "commit_params.svh"

module commit_tb;
    import commit_pkg::*;

    typedef struct {
        commit_op_t op1;
        commit_op_t op0;
        word_t      a1, b1, a0, b0;
        reg_addr_t  d1, d0;
        logic       w1, w0;
        word_t      pc1, pc0, pcb;
        logic       en, ok, stall;
        word_t      addr, rd;
        logic       br, tk, pt;
    } row_t;

    logic       clk = 1'b0;
    logic       rst, stall, dmem_en, dmem_data_ok, branch, taken, pred_taken;
    logic       regwrite1, regwrite0;
    commit_op_t op1, op0;
    word_t      srca1, srcb1, srca0, srcb0, pcplus4_1, pcplus4_0;
    word_t      dmem_addr, dmem_rd, pcbranch;
    reg_addr_t  destreg1, destreg0;
    word_t      result1, result0, redirect_pc, pc_commit;
    logic       ready1, ready0, byp_wen1, byp_wen0, finish, redirect, predict_wen;
    reg_addr_t  byp_destreg1, byp_destreg0;

    row_t        rows[$];
    row_t        cur;
    logic [31:0] rng = 32'd66;
    int          errors = 0;
    bit          table_ready = 1'b0;
    // model of the held response
    logic        ref_ok;
    word_t       ref_rd;

    commit_top u_dut (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic word_t next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic logic touches_memory(commit_op_t op);
        return op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_SW};
    endfunction

    function automatic word_t ref_alu(commit_op_t op, word_t a, word_t b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a + ~b + 32'd1;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            OP_SLL:  return a << (b % 32);
            default: return '0;
        endcase
    endfunction

    function automatic word_t ref_load(commit_op_t op, word_t data, logic [1:0] off);
        word_t bsh;
        word_t hsh;
        bsh = data >> (off * 8);
        hsh = data >> (off[1] ? 16 : 0);
        case (op)
            OP_LB:   return {{24{bsh[7]}}, bsh[7:0]};
            OP_LBU:  return {24'd0, bsh[7:0]};
            OP_LH:   return {{16{hsh[15]}}, hsh[15:0]};
            OP_LHU:  return {16'd0, hsh[15:0]};
            OP_LW:   return data;
            default: return '0;
        endcase
    endfunction

    task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
        if (act !== exp)
        begin
            $display("[ERROR] t=%0t %s expected %h got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_row(row_t r);
        commit_op_t mop;
        word_t      ld;
        logic       fin;
        mop = touches_memory(r.op1) ? r.op1 : r.op0;
        ld  = ref_load(mop, r.ok ? r.rd : ref_rd, r.addr[1:0]);
        fin = !r.en || r.ok || ref_ok;
        check_value("result1", touches_memory(r.op1) ? ld : ref_alu(r.op1, r.a1, r.b1), result1);
        check_value("result0", touches_memory(r.op0) ? ld : ref_alu(r.op0, r.a0, r.b0), result0);
        check_value("ready1", !(touches_memory(r.op1) && !fin), ready1);
        check_value("ready0", !(touches_memory(r.op0) && !fin), ready0);
        check_value("finish", fin, finish);
        check_value("byp_destreg1", r.d1, byp_destreg1);
        check_value("byp_destreg0", r.d0, byp_destreg0);
        check_value("byp_wen1", r.w1, byp_wen1);
        check_value("byp_wen0", r.w0, byp_wen0);
        check_value("redirect", r.br && (r.tk != r.pt), redirect);
        check_value("redirect_pc", r.pt ? r.pc0 : r.pcb, redirect_pc);
        check_value("pc_commit", r.pc1 - `COMMIT_INSTR_BYTES, pc_commit);
        check_value("predict_wen", r.br, predict_wen);
    endtask

    // what the edge at the end of this row does to the held response
    task automatic advance_held(row_t r);
        if (!r.stall)
            ref_ok = 1'b0;
        else if (r.ok)
            ref_ok = 1'b1;
        if (r.stall && r.ok)
            ref_rd = r.rd;
    endtask

    task automatic drive_row(row_t r);
        op1          = r.op1;
        op0          = r.op0;
        srca1        = r.a1;
        srcb1        = r.b1;
        srca0        = r.a0;
        srcb0        = r.b0;
        destreg1     = r.d1;
        destreg0     = r.d0;
        regwrite1    = r.w1;
        regwrite0    = r.w0;
        pcplus4_1    = r.pc1;
        pcplus4_0    = r.pc0;
        pcbranch     = r.pcb;
        dmem_en      = r.en;
        dmem_addr    = r.addr;
        dmem_rd      = r.rd;
        dmem_data_ok = r.ok;
        stall        = r.stall;
        branch       = r.br;
        taken        = r.tk;
        pred_taken   = r.pt;
    endtask

    task automatic start_row(commit_op_t o1, commit_op_t o0);
        word_t rnd;
        rnd       = next_rand();
        cur.op1   = o1;
        cur.op0   = o0;
        cur.a1    = next_rand();
        cur.b1    = next_rand();
        cur.a0    = next_rand();
        cur.b0    = next_rand();
        cur.d1    = rnd[4:0];
        cur.d0    = rnd[9:5];
        cur.w1    = rnd[10];
        cur.w0    = rnd[11];
        cur.pc1   = next_rand() & ~32'd3;
        cur.pc0   = cur.pc1 + 32'd4;
        cur.pcb   = next_rand() & ~32'd3;
        cur.addr  = next_rand();
        cur.rd    = next_rand();
        cur.en    = 1'b0;
        cur.ok    = 1'b0;
        cur.stall = 1'b0;
        cur.br    = 1'b0;
        cur.tk    = 1'b0;
        cur.pt    = 1'b0;
    endtask

    task automatic build_table();
        commit_op_t alu_ops[7] = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT, OP_SLL};
        commit_op_t ld_ops[5]  = '{OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW};
        // first row after reset has a store waiting on memory
        start_row(OP_NOP, OP_SW);
        cur.en    = 1'b1;
        cur.stall = 1'b1;
        rows.push_back(cur);
        for (int k = 0; k < 7; k++)
        begin
            start_row(alu_ops[k], alu_ops[6 - k]);
            rows.push_back(cur);
        end
        start_row(OP_NOP, OP_NOP);
        rows.push_back(cur);
        start_row(OP_SW, OP_ADD);
        cur.en = 1'b1;
        cur.ok = 1'b1;
        rows.push_back(cur);
        // every load at every offset with the lanes alternating
        for (int k = 0; k < 20; k++)
        begin
            if (k % 2 == 0)
                start_row(ld_ops[k / 4], alu_ops[k % 7]);
            else
                start_row(alu_ops[k % 7], ld_ops[k / 4]);
            cur.en        = 1'b1;
            cur.ok        = 1'b1;
            cur.addr[1:0] = k[1:0];
            rows.push_back(cur);
        end
        // response arrives during a stall and must be held
        start_row(OP_NOP, OP_LH);
        cur.en        = 1'b1;
        cur.ok        = 1'b1;
        cur.stall     = 1'b1;
        cur.addr[1:0] = 2'd2;
        rows.push_back(cur);
        cur.ok = 1'b0;
        cur.rd = next_rand();
        rows.push_back(cur);
        rows.push_back(cur);
        cur.stall = 1'b0;
        rows.push_back(cur);
        // next load has no answer yet
        start_row(OP_LBU, OP_OR);
        cur.en        = 1'b1;
        cur.stall     = 1'b1;
        cur.addr[1:0] = 2'd3;
        rows.push_back(cur);
        cur.ok = 1'b1;
        rows.push_back(cur);
        // both mispredicts, two correct predictions, then no branch
        for (int k = 0; k < 5; k++)
        begin
            start_row(OP_ADD, OP_XOR);
            cur.br = (k != 4);
            cur.tk = k inside {0, 2, 4};
            cur.pt = k inside {1, 2};
            rows.push_back(cur);
        end
    endtask

    initial
    begin
        rst = 1'b1;
        build_table();
        table_ready = 1'b1;
        drive_row(rows[0]);
        // a response seen during reset must not survive it
        dmem_data_ok = 1'b1;
        ref_ok = 1'b0;
        ref_rd = rows[0].rd;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        foreach (rows[i])
        begin
            drive_row(rows[i]);
            #2;
            check_row(rows[i]);
            @(posedge clk);
            advance_held(rows[i]);
            #1;
        end
        $display("run complete, %0d error(s)", errors);
        if (errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

    // twice the expected run length
    initial
    begin
        wait (table_ready);
        #((rows.size() + 10) * 4 * 2);
        $display("watchdog: the run did not finish in time");
        errors++;
        $display("run complete, %0d error(s)", errors);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

/* build.f */
+incdir+rtl
rtl/commit_pkg.sv
rtl/lane_if.sv
rtl/mem_if.sv
rtl/late_alu.sv
rtl/load_capture.sv
rtl/commit_merge.sv
rtl/commit_top.sv
sim/commit_checker.sv
sim/commit_tb.sv
